//--- prefetch_pkg.sv
// prefetch buffer shared widths, instruction length encoding and fetcher states
package prefetch_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // byte address width on both the memory and the core side
  localparam int ADDR_W = 32;

  // one uncompressed instruction
  localparam int ILEN = 32;

  // compressed instructions and alignment work in halfwords
  localparam int HALF_W = 16;

  typedef logic [ILEN-1:0] instr_t;
  typedef logic [HALF_W-1:0] half_t;

  ////////////////////////////////////////////////////////////
  // instruction length encoding
  ////////////////////////////////////////////////////////////

  // low two bits of the first halfword, 2'b11 means a 32-bit instruction
  // and anything else a 16-bit compressed one
  localparam logic [1:0] LEN_FULL = 2'b11;

  ////////////////////////////////////////////////////////////
  // fetcher states
  ////////////////////////////////////////////////////////////

  // idle: nothing raised or outstanding
  // req: request raised, waiting for the grant
  // wait: granted, waiting for the response
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'b00,
    FETCH_REQ  = 2'b01,
    FETCH_WAIT = 2'b10
  } fetch_state_e;

endpackage

//--- line_fetcher.sv
// memory side fetch engine, requests sequential lines and drops stale responses
`timescale 1ns/1ps

module line_fetcher import prefetch_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  logic [ADDR_W-1:0]          addr_i,

  input  logic [1:0]                 count_i,

  output logic                       instr_req_o,
  output logic [ADDR_W-1:0]          instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [LINE_WORDS*ILEN-1:0] instr_rdata_i,

  output logic                       push_o,
  output logic [LINE_WORDS*ILEN-1:0] push_line_o,

  output logic                       busy_o
);

  localparam int OFF_BITS = $clog2(LINE_WORDS * 4);
  localparam logic [ADDR_W-1:0] LINE_BYTES = ADDR_W'(LINE_WORDS * 4);

  fetch_state_e state_q, state_d;

  // next line to fetch in program order
  logic [ADDR_W-1:0] fetch_addr_q;
  // address of the request currently raised or outstanding
  logic [ADDR_W-1:0] req_addr_q;
  logic [ADDR_W-1:0] target_line;
  logic              started_q;
  logic              discard_q;
  logic              start_req;

  assign target_line = {addr_i[ADDR_W-1:OFF_BITS], {OFF_BITS{1'b0}}};

  // a branch always restarts, otherwise fetch only while a queue slot is free
  assign start_req = branch_i || (started_q && (count_i < 2'd2));

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (start_req) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      started_q    <= 1'b0;
      discard_q    <= 1'b0;
      fetch_addr_q <= '0;
      req_addr_q   <= '0;
    end else begin
      state_q <= state_d;

      if (branch_i) begin
        started_q <= 1'b1;
      end

      // a request raised or in flight across a branch belongs to the old stream
      if (branch_i && ((state_q == FETCH_REQ) ||
                       ((state_q == FETCH_WAIT) && !instr_rvalid_i))) begin
        discard_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        discard_q <= 1'b0;
      end

      if (branch_i) begin
        fetch_addr_q <= target_line;
      end else if ((state_q == FETCH_REQ) && instr_gnt_i && !discard_q) begin
        fetch_addr_q <= fetch_addr_q + LINE_BYTES;
      end

      // the address is latched once and held until granted
      if ((state_q == FETCH_IDLE) && start_req) begin
        req_addr_q <= branch_i ? target_line : fetch_addr_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign instr_req_o  = (state_q == FETCH_REQ);
  assign instr_addr_o = req_addr_q;

  // a response in the branch cycle itself is dropped by the queue flush
  assign push_o      = instr_rvalid_i && !discard_q;
  assign push_line_o = instr_rdata_i;

  assign busy_o = (state_q != FETCH_IDLE);

  // memory must see a stable address until it grants
  assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request address changed before grant");

  // responses only follow a granted request
  assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (state_q != FETCH_IDLE))
    else $error("response without an outstanding request");

endmodule

//--- line_queue.sv
// two entry store of fetched lines with push, pop and flush
`timescale 1ns/1ps

module line_queue import prefetch_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       flush_i,

  input  logic                       push_i,
  input  logic [LINE_WORDS*ILEN-1:0] push_line_i,

  input  logic                       pop_i,

  output logic [LINE_WORDS*ILEN-1:0] head_line_o,
  output logic [LINE_WORDS*ILEN-1:0] next_line_o,
  output logic [1:0]                 count_o
);

  localparam int LINE_W = LINE_WORDS * ILEN;

  logic [LINE_W-1:0] line_q [2];
  logic              head_q;
  logic [1:0]        count_q;
  logic              tail;

  // with both entries full and a pop the freed head slot is the write slot
  assign tail = head_q ^ count_q[0];

  always_ff @(posedge clk) begin
    if (push_i) begin
      line_q[tail] <= push_line_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= 1'b0;
      count_q <= 2'd0;
    end else if (flush_i) begin
      // flush wins over a push in the same cycle
      head_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (pop_i) begin
        head_q <= ~head_q;
      end
      count_q <= count_q + 2'(push_i) - 2'(pop_i);
    end
  end

  assign head_line_o = line_q[head_q];
  assign next_line_o = line_q[~head_q];
  assign count_o     = count_q;

  // the fetcher only asks for a line while a slot is free
  assert property (@(posedge clk) disable iff (!rst_n || flush_i)
    (push_i && (count_q == 2'd2)) |-> pop_i)
    else $error("push into a full line queue");

  // the aligner only leaves a line it has
  assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> (count_q != 2'd0))
    else $error("pop from an empty line queue");

endmodule

//--- instr_aligner.sv
// core side aligner, picks the instruction at the pc and retires lines from the queue
`timescale 1ns/1ps

module instr_aligner import prefetch_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  logic [ADDR_W-1:0]          addr_i,

  input  logic [LINE_WORDS*ILEN-1:0] head_line_i,
  input  logic [LINE_WORDS*ILEN-1:0] next_line_i,
  input  logic [1:0]                 count_i,

  input  logic                       ready_i,
  output logic                       valid_o,
  output instr_t                     rdata_o,
  output logic [ADDR_W-1:0]          addr_o,

  output logic                       pop_o
);

  localparam int OFF_BITS = $clog2(LINE_WORDS * 4);
  localparam int HW_IDX   = OFF_BITS - 1;

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_next;
  logic [HW_IDX-1:0] lo_idx;
  logic [HW_IDX-1:0] hi_idx;
  logic              last_half;
  half_t             lo_half;
  half_t             hi_half;
  logic              is_full;
  logic              crossword;
  logic              head_present;
  logic              next_present;
  logic              transfer;

  ////////////////////////////////////////////////////////////
  // halfword extraction
  ////////////////////////////////////////////////////////////

  assign lo_idx    = pc_q[OFF_BITS-1:1];
  // wraps to halfword 0, which is the start of the next line
  assign hi_idx    = lo_idx + 1'b1;
  assign last_half = &lo_idx;

  assign lo_half = head_line_i[lo_idx*HALF_W +: HALF_W];
  assign hi_half = last_half ? next_line_i[hi_idx*HALF_W +: HALF_W]
                             : head_line_i[hi_idx*HALF_W +: HALF_W];

  assign is_full   = (lo_half[1:0] == LEN_FULL);
  // full instruction starting on the last halfword needs both lines
  assign crossword = last_half && is_full;

  assign head_present = (count_i != 2'd0);
  assign next_present = (count_i == 2'd2);

  ////////////////////////////////////////////////////////////
  // core interface
  ////////////////////////////////////////////////////////////

  assign valid_o = head_present && (!crossword || next_present) && !branch_i;
  assign rdata_o = {hi_half, lo_half};
  assign addr_o  = pc_q;

  assign transfer = valid_o && ready_i;
  assign pc_next  = pc_q + (is_full ? ADDR_W'(4) : ADDR_W'(2));

  // the head line is done once the pc moves past it
  assign pop_o = transfer && (pc_next[ADDR_W-1:OFF_BITS] != pc_q[ADDR_W-1:OFF_BITS]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (branch_i) begin
      pc_q <= addr_i;
    end else if (transfer) begin
      pc_q <= pc_next;
    end
  end

  // the core should only be ready once it sees an instruction
  assert property (@(posedge clk) disable iff (!rst_n)
    ready_i |-> valid_o)
    else $error("core ready while no instruction is valid");

endmodule

//--- prefetch_buffer.sv
// instruction prefetch buffer top, connects fetcher, line queue and aligner
`timescale 1ns/1ps

module prefetch_buffer import prefetch_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  logic [ADDR_W-1:0]          addr_i,

  input  logic                       ready_i,
  output logic                       valid_o,
  output instr_t                     rdata_o,
  output logic [ADDR_W-1:0]          addr_o,

  output logic                       instr_req_o,
  output logic [ADDR_W-1:0]          instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [LINE_WORDS*ILEN-1:0] instr_rdata_i,

  output logic                       busy_o
);

  localparam int LINE_W = LINE_WORDS * ILEN;

  logic              push;
  logic [LINE_W-1:0] push_line;
  logic              pop;
  logic [LINE_W-1:0] head_line;
  logic [LINE_W-1:0] next_line;
  logic [1:0]        count;

  line_fetcher #(
    .LINE_WORDS(LINE_WORDS)
  ) line_fetcher_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .addr_i        (addr_i),
    .count_i       (count),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .push_o        (push),
    .push_line_o   (push_line),
    .busy_o        (busy_o)
  );

  // a branch empties the store in the same edge the fetcher restarts
  line_queue #(
    .LINE_WORDS(LINE_WORDS)
  ) line_queue_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (branch_i),
    .push_i     (push),
    .push_line_i(push_line),
    .pop_i      (pop),
    .head_line_o(head_line),
    .next_line_o(next_line),
    .count_o    (count)
  );

  instr_aligner #(
    .LINE_WORDS(LINE_WORDS)
  ) instr_aligner_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .branch_i   (branch_i),
    .addr_i     (addr_i),
    .head_line_i(head_line),
    .next_line_i(next_line),
    .count_i    (count),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .rdata_o    (rdata_o),
    .addr_o     (addr_o),
    .pop_o      (pop)
  );

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset source, 10 ns period with reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_imem.sv
// testbench instruction memory with random grant and response delays and protocol checks
`timescale 1ns/1ps

module tb_imem import prefetch_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  logic [ADDR_W-1:0]          addr_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output logic [LINE_WORDS*ILEN-1:0] rdata_o,
  output int                         violations_o
);

  localparam int OFF_BITS = $clog2(LINE_WORDS * 4);

  logic [31:0]       lfsr_q;
  logic [ADDR_W-1:0] resp_addr;
  logic              pending;
  logic              armed;
  int                gnt_wait;
  int                resp_wait;
  int                draw_val;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // halfword at byte address a is {a[15:2], len}
  function automatic half_t mem_half(input logic [ADDR_W-1:0] a);
    logic [1:0] len;
    len = (((a >> 1) % 3) == 0) ? LEN_FULL : 2'b01;
    return {a[15:2], len};
  endfunction

  function automatic logic [LINE_WORDS*ILEN-1:0] make_line(input logic [ADDR_W-1:0] base);
    logic [LINE_WORDS*ILEN-1:0] line;
    for (int i = 0; i < LINE_WORDS * 2; i++) begin
      line[i*HALF_W +: HALF_W] = mem_half(base + ADDR_W'(2 * i));
    end
    return line;
  endfunction

  initial begin
    lfsr_q = 32'h2adf;
    violations_o = 0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      pending   = 1'b0;
      armed     = 1'b0;
      gnt_wait  = 0;
      resp_wait = 0;
    end else begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;

      if (req_i && (addr_i[OFF_BITS-1:0] != '0)) begin
        $display("memory protocol violation at %0t: request address %h is not line aligned",
                 $time, addr_i);
        violations_o = violations_o + 1;
      end
      if (req_i && (pending || rvalid_o)) begin
        $display("memory protocol violation at %0t: request raised while another is outstanding",
                 $time);
        violations_o = violations_o + 1;
      end

      if (gnt_o) begin
        // granted on this edge, response comes 1 to 3 cycles later
        pending   = 1'b1;
        resp_addr = addr_i;
        draw_bits(2, draw_val);
        resp_wait = draw_val % 3;
      end else if (pending) begin
        if (resp_wait == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= make_line(resp_addr);
          pending  = 1'b0;
        end else begin
          resp_wait = resp_wait - 1;
        end
      end else if (req_i) begin
        if (!armed) begin
          draw_bits(2, draw_val);
          gnt_wait = draw_val;
          armed    = 1'b1;
        end
        if (gnt_wait == 0) begin
          gnt_o <= 1'b1;
          armed = 1'b0;
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

endmodule

//--- tb_prefetch_buffer.sv
// testbench top for the prefetch buffer, branch table with reference pc model
`timescale 1ns/1ps

module tb_prefetch_buffer import prefetch_pkg::*;;

  localparam int LINE_WORDS = 4;
  localparam int NUM_ROWS   = 9;
  localparam int OFF_BITS   = $clog2(LINE_WORDS * 4);

  logic                       clk;
  logic                       rst_n;
  logic                       branch_i;
  logic [ADDR_W-1:0]          addr_i;
  logic                       ready_i;
  logic                       valid_o;
  instr_t                     rdata_o;
  logic [ADDR_W-1:0]          addr_o;
  logic                       instr_req_o;
  logic [ADDR_W-1:0]          instr_addr_o;
  logic                       instr_gnt_i;
  logic                       instr_rvalid_i;
  logic [LINE_WORDS*ILEN-1:0] instr_rdata_i;
  logic                       busy_o;
  int                         violations;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  // branch target, transfers to check, random ready
  logic [ADDR_W-1:0] tgt_tab [NUM_ROWS] = '{
    32'h0000_0100, 32'h0000_020e, 32'h0000_0302, 32'h0000_0406, 32'h0000_050e,
    32'h0000_0a0a, 32'h0000_1ffe, 32'h0000_0c00, 32'h0000_0d04
  };
  int n_tab [NUM_ROWS] = '{24, 12, 3, 1, 40, 30, 20, 2, 16};
  bit rand_tab [NUM_ROWS] = '{0, 0, 0, 0, 1, 1, 0, 1, 0};

  logic [31:0]       lfsr_q;
  int                errors;
  logic              hold_q;
  logic [ADDR_W-1:0] held_addr;
  instr_t            held_data;
  logic              outstanding_q;

  tb_clock_gen tb_clock_gen_i (
    .clk  (clk),
    .rst_n(rst_n)
  );

  prefetch_buffer #(
    .LINE_WORDS(LINE_WORDS)
  ) prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .addr_i        (addr_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .busy_o        (busy_o)
  );

  tb_imem #(
    .LINE_WORDS(LINE_WORDS)
  ) tb_imem_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (instr_req_o),
    .addr_i      (instr_addr_o),
    .gnt_o       (instr_gnt_i),
    .rvalid_o    (instr_rvalid_i),
    .rdata_o     (instr_rdata_i),
    .violations_o(violations)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic half_t ref_half(input logic [ADDR_W-1:0] a);
    logic [1:0] len;
    len = (((a >> 1) % 3) == 0) ? LEN_FULL : 2'b01;
    return {a[15:2], len};
  endfunction

  // upper half of a compressed instruction on a line's last halfword
  // may come from a line not yet fetched
  function automatic logic same_instr(input logic [ADDR_W-1:0] a, input instr_t exp,
                                      input instr_t act);
    if ((exp[1:0] != LEN_FULL) && (&a[OFF_BITS-1:1])) begin
      return exp[HALF_W-1:0] == act[HALF_W-1:0];
    end
    return exp == act;
  endfunction

  ////////////////////////////////////////////////////////////
  // row application
  ////////////////////////////////////////////////////////////

  task automatic run_row(input logic [ADDR_W-1:0] target, input int n, input bit rnd);
    logic [ADDR_W-1:0] pc;
    instr_t            exp;
    int                done;
    logic              want;
    @(posedge clk);
    branch_i <= 1'b1;
    addr_i   <= target;
    ready_i  <= 1'b0;
    @(posedge clk);
    branch_i <= 1'b0;
    pc   = target;
    done = 0;
    while (done < n) begin
      @(posedge clk);
      if (valid_o && ready_i) begin
        exp = {ref_half(pc + 2), ref_half(pc)};
        if (addr_o != pc) begin
          $display("ERR %0t addr_o expected %h actual %h", $time, pc, addr_o);
          errors++;
        end
        if (!same_instr(pc, exp, rdata_o)) begin
          $display("ERR %0t rdata_o expected %h actual %h", $time, exp, rdata_o);
          errors++;
        end
        pc   = pc + ((exp[1:0] == LEN_FULL) ? 4 : 2);
        done = done + 1;
      end
      want = 1'b1;
      if (rnd) begin
        lfsr_q = lfsr_step(lfsr_q);
        want   = lfsr_q[0];
      end
      // ready only follows a valid that was held, so it never leads valid
      ready_i <= want && (done < n) && valid_o && !ready_i;
    end
  endtask

  // held outputs must not move under back-pressure
  always @(posedge clk) begin
    if (rst_n) begin
      if (branch_i && valid_o) begin
        $display("ERR %0t valid_o expected 0 actual %b", $time, valid_o);
        errors++;
      end
      if (hold_q) begin
        if (!valid_o && !branch_i) begin
          $display("ERR %0t valid_o expected 1 actual %b", $time, valid_o);
          errors++;
        end
        if (addr_o != held_addr) begin
          $display("ERR %0t addr_o expected %h actual %h", $time, held_addr, addr_o);
          errors++;
        end
        if (!same_instr(held_addr, held_data, rdata_o)) begin
          $display("ERR %0t rdata_o expected %h actual %h", $time, held_data, rdata_o);
          errors++;
        end
      end
      hold_q    <= valid_o && !ready_i && !branch_i;
      held_addr <= addr_o;
      held_data <= rdata_o;
    end else begin
      hold_q <= 1'b0;
    end
  end

  // busy while a request is raised or granted and not yet answered
  always @(posedge clk) begin
    if (rst_n) begin
      if (busy_o != (instr_req_o || outstanding_q)) begin
        $display("ERR %0t busy_o expected %b actual %b", $time,
                 instr_req_o || outstanding_q, busy_o);
        errors++;
      end
      if (instr_req_o && instr_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end else begin
      outstanding_q <= 1'b0;
    end
  end

  // watchdog, 20 cycles per transfer plus slack
  initial begin
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += n_tab[r];
    end
    #((total * 20 + 100) * 10);
    $display("timeout: transfers did not complete in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    branch_i = 1'b0;
    addr_i   = '0;
    ready_i  = 1'b0;
    errors   = 0;
    lfsr_q   = 32'h2adf;
    @(posedge rst_n);
    // idle until the first branch
    repeat (6) begin
      @(posedge clk);
      if (valid_o || instr_req_o || busy_o) begin
        $display("buffer active before the first branch at %0t", $time);
        errors++;
      end
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(tgt_tab[r], n_tab[r], rand_tab[r]);
    end
    repeat (10) @(posedge clk);
    $display("errors: %0d data, %0d memory protocol", errors, violations);
    if ((errors == 0) && (violations == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
prefetch_pkg.sv
line_fetcher.sv
line_queue.sv
instr_aligner.sv
prefetch_buffer.sv
tb_clock_gen.sv
tb_imem.sv
tb_prefetch_buffer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_prefetch_buffer
FILELIST  ?= compile.f
PASS_MSG  := *** TEST PASSED ***

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
